// File: files.f
logic/game_pkg.sv
logic/frame_if.sv
logic/button_debounce.sv
logic/playfield.sv
logic/matrix_scan.sv
logic/max7219_serializer.sv
logic/game_top.sv
testbench/tb_clock.sv
testbench/game_asserts.sv
testbench/tb_game.sv

// File: logic/button_debounce.sv
//########################################
// Debouncer for one active-low push button
// Gives a single-clock pulse per accepted press
//########################################
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
	parameter int DEBOUNCE_CYCLES = 50000
) (
	input  logic clk,
	input  logic arst_n,
	input  logic button_n,
	output logic press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [1:0] sync_n;
	logic level;
	logic accepted;
	logic [CNT_W-1:0] stable_cnt;
	logic settle;

	// Pressed level, high while held
	assign level = ~sync_n[1];
	// Last clock of a full stable window
	assign settle = (level != accepted) && (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// Released button reads high
			sync_n     <= 2'b11;
			accepted   <= 1'b0;
			stable_cnt <= '0;
			press      <= 1'b0;
		end else begin
			sync_n <= {sync_n[0], button_n};
			press  <= settle && level;
			// Count only while the level differs from the accepted one
			if (level == accepted) begin
				stable_cnt <= '0;
			end else if (settle) begin
				accepted   <= level;
				stable_cnt <= '0;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/frame_if.sv
//########################################
// Picture of the playfield
// Game logic drives it, display scanner reads it
//########################################
`timescale 1ns/1ps
`default_nettype none

interface frame_if;

	// Obstacle rows, row 0 at the top
	game_pkg::row_t [game_pkg::MATRIX_SIZE-1:0] rows;
	// Player dot lives in the bottom row
	game_pkg::row_idx_t player_col;
	// Game state flags
	logic running;
	logic game_over;

	modport producer (output rows, player_col, running, game_over);
	modport consumer (input rows, player_col, running, game_over);

endinterface

`default_nettype wire

// File: logic/game_pkg.sv
//########################################
// Shared definitions of the matrix game
// Sizes, MAX7219 registers, LFSR constants
// and the command word seen two ways
//########################################
`default_nettype none

package game_pkg;

	// Matrix geometry
	localparam int MATRIX_SIZE = 8;

	// Bit c set means column c lit
	typedef logic [MATRIX_SIZE-1:0] row_t;
	typedef logic [2:0] row_idx_t;

	// ########################################
	// MAX7219 register addresses
	// Digits 1 to 8 use their own number
	localparam logic [3:0] REG_DECODE     = 4'h9;
	localparam logic [3:0] REG_INTENSITY  = 4'hA;
	localparam logic [3:0] REG_SCAN_LIMIT = 4'hB;
	localparam logic [3:0] REG_SHUTDOWN   = 4'hC;
	localparam logic [3:0] REG_TEST       = 4'hF;

	// Serializer shifts raw MSB first, scanner fills the fields
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [3:0] unused;
			logic [3:0] addr;
			logic [7:0] data;
		} fields;
	} max_word_u;

	// Game start values
	localparam logic [7:0] LFSR_SEED        = 8'hA5;
	localparam row_idx_t   PLAYER_START_COL = 3'd3;

endpackage

`default_nettype wire

// File: logic/game_top.sv
//########################################
// Top level of the 8x8 obstacle game
// Buttons in, MAX7219 pins and game_over out
//########################################
`timescale 1ns/1ps
`default_nettype none

module game_top #(
	parameter int DEBOUNCE_CYCLES = 50000,
	parameter int STEP_CYCLES = 12500000,
	parameter int SCLK_DIV = 4,
	parameter logic [3:0] INTENSITY = 4'hA
) (
	input  logic clk,
	input  logic arst_n,
	input  logic start_button_n,
	input  logic left_button_n,
	input  logic right_button_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk,
	output logic game_over
);

	logic start_press;
	logic left_press;
	logic right_press;
	logic word_valid;
	logic word_ready;
	game_pkg::max_word_u word;

	frame_if frame ();

	// ########################################
	// Buttons
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_start_db (
		.clk(clk), .arst_n(arst_n), .button_n(start_button_n), .press(start_press)
	);
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_left_db (
		.clk(clk), .arst_n(arst_n), .button_n(left_button_n), .press(left_press)
	);
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_right_db (
		.clk(clk), .arst_n(arst_n), .button_n(right_button_n), .press(right_press)
	);

	// ########################################
	// Game
	playfield #(.STEP_CYCLES(STEP_CYCLES)) u_playfield (
		.clk(clk), .arst_n(arst_n), .start(start_press),
		.move_left(left_press), .move_right(right_press), .frame(frame.producer)
	);

	assign game_over = frame.game_over;

	// ########################################
	// Display chain
	matrix_scan #(.INTENSITY(INTENSITY)) u_scan (
		.clk(clk), .arst_n(arst_n), .frame(frame.consumer),
		.word_ready(word_ready), .word_valid(word_valid), .word(word)
	);

	max7219_serializer #(.SCLK_DIV(SCLK_DIV)) u_serializer (
		.clk(clk), .arst_n(arst_n), .word_valid(word_valid), .word(word),
		.word_ready(word_ready), .max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs), .max7219_clk(max7219_clk)
	);

endmodule

`default_nettype wire

// File: logic/matrix_scan.sv
//########################################
// MAX7219 word sequencer
// Five setup words after reset, then endless
// refresh passes over digits 1 to 8
//########################################
`timescale 1ns/1ps
`default_nettype none

module matrix_scan #(
	parameter logic [3:0] INTENSITY = 4'hA
) (
	input  logic clk,
	input  logic arst_n,
	frame_if.consumer frame,
	input  logic word_ready,
	output logic word_valid,
	output game_pkg::max_word_u word
);

	localparam int LAST = game_pkg::MATRIX_SIZE - 1;
	localparam game_pkg::row_idx_t SETUP_LAST = 3'd4;
	localparam game_pkg::row_idx_t DIGIT_LAST = game_pkg::row_idx_t'(LAST);

	logic in_setup;
	game_pkg::row_idx_t idx;
	logic load;
	game_pkg::row_t [LAST:0] picture_live;
	game_pkg::row_t [LAST:0] picture_src;
	game_pkg::row_t [LAST:0] snapshot;
	game_pkg::max_word_u next_word;

	// Next word may go in when the slot is empty or draining
	assign load = !word_valid || word_ready;

	// Obstacles with the player dot in the bottom row
	always_comb begin
		picture_live = frame.rows;
		picture_live[LAST] = frame.rows[LAST] | (game_pkg::row_t'(1) << frame.player_col);
		// Digit 1 takes the live picture, the rest the snapshot
		picture_src = (idx == '0) ? picture_live : snapshot;
	end

	// ########################################
	// Word builder

	always_comb begin
		next_word.raw = '0;
		if (in_setup) begin
			case (idx)
				3'd0: next_word.fields.addr = game_pkg::REG_DECODE;
				3'd1: begin
					next_word.fields.addr = game_pkg::REG_INTENSITY;
					next_word.fields.data = {4'h0, INTENSITY};
				end
				3'd2: begin
					next_word.fields.addr = game_pkg::REG_SCAN_LIMIT;
					next_word.fields.data = 8'h07;
				end
				3'd3: begin
					next_word.fields.addr = game_pkg::REG_SHUTDOWN;
					next_word.fields.data = 8'h01;
				end
				default: next_word.fields.addr = game_pkg::REG_TEST;
			endcase
		end else begin
			// Digit k+1 holds column k, bit r from row r
			next_word.fields.addr = {1'b0, idx} + 4'd1;
			for (int r = 0; r <= LAST; r++) begin
				next_word.fields.data[r] = picture_src[r][idx];
			end
		end
	end

	// ########################################
	// Sequencer

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			word_valid <= 1'b0;
			in_setup   <= 1'b1;
			idx        <= '0;
		end else if (load) begin
			word_valid <= 1'b1;
			if (in_setup && idx == SETUP_LAST) begin
				in_setup <= 1'b0;
				idx      <= '0;
			end else if (!in_setup && idx == DIGIT_LAST) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// Word and picture copy
	always_ff @(posedge clk) begin
		if (load) begin
			word <= next_word;
		end
		// Picture frozen for the whole pass
		if (load && !in_setup && idx == '0) begin
			snapshot <= picture_live;
		end
	end

endmodule

`default_nettype wire

// File: logic/max7219_serializer.sv
//########################################
// Serial link to the MAX7219
// One 16-bit word per ncs frame, MSB first,
// 34 clk phases from accept to ready
//########################################
`timescale 1ns/1ps
`default_nettype none

module max7219_serializer #(
	parameter int SCLK_DIV = 4
) (
	input  logic clk,
	input  logic arst_n,
	input  logic word_valid,
	input  game_pkg::max_word_u word,
	output logic word_ready,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
	// Phase 0 lead, 1 to 31 bits, 32 hold, 33 ncs high
	localparam logic [5:0] HOLD_PHASE = 6'd32;
	localparam logic [5:0] LAST_PHASE = 6'd33;

	logic busy;
	logic [DIV_W-1:0] div_cnt;
	logic [5:0] phase;
	logic [15:0] shift;

	assign word_ready  = !busy;
	// Fully shifted word leaves din low
	assign max7219_din = shift[15];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy        <= 1'b0;
			div_cnt     <= '0;
			phase       <= '0;
			shift       <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else if (!busy) begin
			// Accept a word and open the frame
			if (word_valid) begin
				busy        <= 1'b1;
				div_cnt     <= '0;
				phase       <= '0;
				shift       <= word.raw;
				max7219_ncs <= 1'b0;
			end
		end else if (div_cnt != DIV_W'(SCLK_DIV - 1)) begin
			div_cnt <= div_cnt + 1'b1;
		end else begin
			div_cnt <= '0;
			if (phase == LAST_PHASE) begin
				busy <= 1'b0;
			end else begin
				phase <= phase + 1'b1;
				if (phase == HOLD_PHASE) begin
					// Rising ncs latches the word
					max7219_ncs <= 1'b1;
				end else if (phase[0]) begin
					// Falling edge, next bit onto din
					max7219_clk <= 1'b0;
					shift       <= {shift[14:0], 1'b0};
				end else begin
					max7219_clk <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/playfield.sv
//########################################
// Game state of the falling obstacle game
// Step timer, LFSR, row registers, player and
// collision, published through frame_if
//########################################
`timescale 1ns/1ps
`default_nettype none

module playfield #(
	parameter int STEP_CYCLES = 12500000
) (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  logic move_left,
	input  logic move_right,
	frame_if.producer frame
);

	localparam int TIMER_W = $clog2(STEP_CYCLES + 1);
	localparam int LAST = game_pkg::MATRIX_SIZE - 1;
	localparam game_pkg::row_idx_t MAX_COL = game_pkg::row_idx_t'(LAST);

	logic [TIMER_W-1:0] step_timer;
	logic [7:0] lfsr;
	logic [7:0] lfsr_next;
	game_pkg::row_t new_top;
	game_pkg::row_idx_t col_next;
	logic step;
	logic hit;

	// ########################################
	// Next values

	always_comb begin
		// Shift left, taps 7 5 4 3
		lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
		// Bit 3 decides if a new obstacle appears
		if (lfsr_next[3]) begin
			new_top = game_pkg::row_t'(1) << lfsr_next[2:0];
		end else begin
			new_top = '0;
		end
	end

	always_comb begin
		col_next = frame.player_col;
		// Frozen after a crash
		if (!frame.game_over) begin
			// Clamp at both edges, left wins a tie
			if (move_left && frame.player_col != '0) begin
				col_next = frame.player_col - 1'b1;
			end else if (move_right && frame.player_col != MAX_COL) begin
				col_next = frame.player_col + 1'b1;
			end
		end
	end

	// One step per STEP_CYCLES clocks of running
	assign step = frame.running && (step_timer == TIMER_W'(STEP_CYCLES - 1));
	// Row 6 becomes the new bottom row
	assign hit = frame.rows[LAST-1][col_next];

	// ########################################
	// State registers

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			step_timer       <= '0;
			lfsr             <= game_pkg::LFSR_SEED;
			frame.rows       <= '0;
			frame.player_col <= game_pkg::PLAYER_START_COL;
			frame.running    <= 1'b0;
			frame.game_over  <= 1'b0;
		end else if (start) begin
			// Fresh game, same obstacle sequence each time
			step_timer       <= '0;
			lfsr             <= game_pkg::LFSR_SEED;
			frame.rows       <= '0;
			frame.player_col <= game_pkg::PLAYER_START_COL;
			frame.running    <= 1'b1;
			frame.game_over  <= 1'b0;
		end else begin
			frame.player_col <= col_next;
			if (step) begin
				step_timer <= '0;
				lfsr       <= lfsr_next;
				// Rows move down, old bottom row drops out
				frame.rows <= {frame.rows[LAST-1:0], new_top};
				// Obstacle lands on the player
				if (hit) begin
					frame.running   <= 1'b0;
					frame.game_over <= 1'b1;
				end
			end else if (frame.running) begin
				step_timer <= step_timer + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module tb_game \
	|| { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_game +verilator+error+limit+100)"
echo "$out"
echo "$out" | grep -qxF "=== PASS ===" && echo "run passed" || { echo "run failed"; exit 1; }

// File: testbench/game_asserts.sv
//########################################
// Bound checks on the MAX7219 serializer
// Frame shape and the word handshake
//########################################
`timescale 1ns/1ps
`default_nettype none

module game_asserts (
	input logic clk,
	input logic arst_n,
	input logic word_valid,
	input game_pkg::max_word_u word,
	input logic word_ready,
	input logic max7219_ncs,
	input logic max7219_clk
);

	// Failure tallies, one per property
	int clock_fails = 0;
	int hold_fails = 0;
	int busy_fails = 0;

	// Serial clock parked low outside a frame
	idle_clock_low: assert property (@(posedge clk) disable iff (!arst_n)
		max7219_ncs |-> !max7219_clk)
	else begin
		$error("max7219_clk high while ncs is high");
		clock_fails++;
	end

	// Offered word stays put until taken
	word_held: assert property (@(posedge clk) disable iff (!arst_n)
		(word_valid && !word_ready) |=> (word_valid && $stable(word.raw)))
	else begin
		$error("word_valid or word changed before word_ready");
		hold_fails++;
	end

	// No new word while a frame is open
	busy_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
		!max7219_ncs |-> !word_ready)
	else begin
		$error("word_ready high while ncs is low");
		busy_fails++;
	end

endmodule

bind max7219_serializer game_asserts u_asserts (
	.clk(clk), .arst_n(arst_n), .word_valid(word_valid), .word(word),
	.word_ready(word_ready), .max7219_ncs(max7219_ncs), .max7219_clk(max7219_clk)
);

`default_nettype wire

// File: testbench/game_testdata.txt
// Command digit, then 64-bit argument. 1 start, 2 left, 3 right (press count), 4 wait clocks,
// 5 next picture rows 0..7, 6 bare player pictures (row 7 bytes, zero skipped), 7 game_over
6_0000000000000008 // player at column 3
7_0000000000000000
2_0000000000000004 // fourth press clamps at 0
6_0000000000040201
3_0000000000000008 // eighth press clamps at 7
6_0002040810204080
1_0000000000000000
5_00_00_00_00_00_00_00_08
5_04_00_00_00_00_00_00_08 // step 1
2_0000000000000001
5_04_00_00_00_00_00_00_04
5_00_04_00_00_00_00_00_04
5_04_00_04_00_00_00_00_04
5_00_04_00_04_00_00_00_04
5_02_00_04_00_04_00_00_04
5_00_02_00_04_00_04_00_04
5_00_00_02_00_04_00_04_04
5_40_00_00_02_00_04_00_04 // step 8 hits column 2
4_0000000000002EE0
7_0000000000000001
1_0000000000000000
5_00_00_00_00_00_00_00_08
5_04_00_00_00_00_00_00_08
5_00_04_00_00_00_00_00_08
7_0000000000000000
0_0000000000000000

// File: testbench/tb_clock.sv
//########################################
// Clock and reset source for the testbench
// 40 ns clock, reset held for 16 cycles
//########################################
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD_NS = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Release on a falling edge, away from the DUT's sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/tb_game.sv
//########################################
// Testbench for the 8x8 obstacle game
// Plays the button script from the data file and
// decodes the MAX7219 stream back into pictures
//########################################
`timescale 1ns/1ps
`default_nettype none

module tb_game;

	// Scaled-down DUT timing
	localparam int DEBOUNCE = 4;
	localparam int STEP = 4000;
	localparam int SCLK_DIV = 2;
	localparam logic [3:0] INTENSITY = 4'h5;
	// Longer than two refresh passes
	localparam int SETTLE_CLOCKS = 1400;
	localparam int PICTURE_TIMEOUT = 8000;
	localparam int SCRIPT_DEPTH = 64;

	logic clk;
	logic arst_n;
	logic start_button_n;
	logic left_button_n;
	logic right_button_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;
	logic game_over;

	// Command nibble on top of a 64-bit argument
	logic [67:0] script [SCRIPT_DEPTH];
	// Distinct pictures with row 0 in the top byte
	logic [63:0] pictures [$];
	logic [63:0] last_picture;
	logic have_picture = 1'b0;
	logic [7:0] columns [8];
	logic [15:0] shift_word;
	logic ncs_prev = 1'b1;
	logic sclk_prev = 1'b0;
	logic aborted = 1'b0;
	int bit_count = 0;
	int word_count = 0;
	int digit = 0;
	int checked = 0;
	int errors = 0;

	tb_clock #(.HALF_PERIOD_NS(20), .RESET_CYCLES(16)) u_clock (.clk(clk), .arst_n(arst_n));

	game_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE), .STEP_CYCLES(STEP),
		.SCLK_DIV(SCLK_DIV), .INTENSITY(INTENSITY)
	) DUT (
		.clk(clk), .arst_n(arst_n), .start_button_n(start_button_n),
		.left_button_n(left_button_n), .right_button_n(right_button_n),
		.max7219_din(max7219_din), .max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk), .game_over(game_over)
	);

	// ########################################
	// Helpers

	// Expected setup words in send order
	function automatic logic [15:0] setup_word(input int n);
		case (n)
			0: return 16'h0900;
			1: return {8'h0A, 4'h0, INTENSITY};
			2: return 16'h0B07;
			3: return 16'h0C01;
			default: return 16'h0F00;
		endcase
	endfunction

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("MISMATCH at %0d ns: %s got %b expected %b", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic set_button(input int which, input logic level);
		case (which)
			0: start_button_n = level;
			1: left_button_n = level;
			default: right_button_n = level;
		endcase
	endtask

	// Hold past the debounce window and let the picture settle
	task automatic press_button(input int which, input int count);
		for (int n = 0; n < count; n++) begin
			@(negedge clk);
			set_button(which, 1'b0);
			repeat (DEBOUNCE + 6) @(negedge clk);
			set_button(which, 1'b1);
			repeat (SETTLE_CLOCKS) @(negedge clk);
		end
	endtask

	task automatic expect_picture(input logic [63:0] want);
		int waited;
		logic [63:0] got;
		waited = 0;
		while (pictures.size() == 0 && waited < PICTURE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (pictures.size() == 0) begin
			$display("ERROR at %0d ns: no new picture within %0d clocks", $time, waited);
			errors++;
			aborted = 1'b1;
		end else begin
			got = pictures.pop_front();
			checked++;
			if (got !== want) begin
				$display("MISMATCH at %0d ns: max7219_din picture got %h expected %h",
					$time, got, want);
				errors++;
			end
		end
	endtask

	// Setup words first and then digits 1 to 8 over and over
	task automatic take_word(input logic [15:0] w);
		logic [63:0] picture;
		logic [7:0] want_addr;
		want_addr = 8'(digit + 1);
		if (word_count < 5) begin
			if (w !== setup_word(word_count)) begin
				$display("MISMATCH at %0d ns: max7219_din word got %h expected %h",
					$time, w, setup_word(word_count));
				errors++;
			end
		end else begin
			if (w[15:8] !== want_addr) begin
				$display("MISMATCH at %0d ns: max7219_din address got %h expected %h",
					$time, w[15:8], want_addr);
				errors++;
			end
			columns[digit] = w[7:0];
			if (digit == 7) begin
				// Bit r of digit k+1 is row r of column k
				for (int r = 0; r < 8; r++) begin
					for (int k = 0; k < 8; k++) begin
						picture[(7 - r) * 8 + k] = columns[k][r];
					end
				end
				if (!have_picture || picture !== last_picture) begin
					pictures.push_back(picture);
					last_picture = picture;
					have_picture = 1'b1;
				end
			end
			digit = (digit + 1) % 8;
		end
		word_count++;
	endtask

	// ########################################
	// Serial monitor on the falling system clock
	always @(negedge clk) begin
		if (!arst_n) begin
			ncs_prev = 1'b1;
			sclk_prev = 1'b0;
			bit_count = 0;
		end else begin
			// Bit taken on each rising serial clock inside a frame
			if (!max7219_ncs && max7219_clk && !sclk_prev) begin
				shift_word = {shift_word[14:0], max7219_din};
				bit_count++;
			end
			if (max7219_ncs && !ncs_prev) begin
				if (bit_count != 16) begin
					$display("MISMATCH at %0d ns: max7219_clk edges per frame got %0d expected 16",
						$time, bit_count);
					errors++;
				end
				take_word(shift_word);
				bit_count = 0;
			end
			ncs_prev = max7219_ncs;
			sclk_prev = max7219_clk;
		end
	end

	// ########################################
	// Script player
	initial begin
		int pc;
		int waited;
		logic [3:0] cmd;
		logic [63:0] arg;
		start_button_n = 1'b1;
		left_button_n = 1'b1;
		right_button_n = 1'b1;
		for (int i = 0; i < SCRIPT_DEPTH; i++) begin
			script[i] = '0;
		end
		$readmemh("testbench/game_testdata.txt", script);

		// Pins idle while reset is held
		@(negedge clk);
		check_bit("max7219_ncs", max7219_ncs, 1'b1);
		check_bit("max7219_clk", max7219_clk, 1'b0);
		check_bit("max7219_din", max7219_din, 1'b0);
		check_bit("game_over", game_over, 1'b0);
		waited = 0;
		while (arst_n !== 1'b1 && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (arst_n !== 1'b1) begin
			$display("ERROR at %0d ns: reset was never released", $time);
			errors++;
			aborted = 1'b1;
		end

		pc = 0;
		while (!aborted && pc < SCRIPT_DEPTH && script[pc][67:64] != 4'h0) begin
			cmd = script[pc][67:64];
			arg = script[pc][63:0];
			case (cmd)
				4'h1: press_button(0, 1);
				4'h2: press_button(1, int'(arg[31:0]));
				4'h3: press_button(2, int'(arg[31:0]));
				4'h4: repeat (arg[31:0]) @(negedge clk);
				4'h5: expect_picture(arg);
				4'h6: begin
					// One bare player picture per nonzero byte
					for (int b = 7; b >= 0; b--) begin
						if (!aborted && arg[b * 8 +: 8] != 8'h00) begin
							expect_picture({56'h0, arg[b * 8 +: 8]});
						end
					end
				end
				4'h7: begin
					check_bit("game_over", game_over, arg[0]);
					if (pictures.size() != 0) begin
						$display("ERROR at %0d ns: picture changed while it should hold",
							$time);
						errors++;
					end
				end
				default: begin
					$display("ERROR: unknown script command %h on entry %0d", cmd, pc);
					errors++;
					aborted = 1'b1;
				end
			endcase
			pc++;
		end

		if (checked == 0) begin
			$display("ERROR at %0d ns: no picture was checked", $time);
			errors++;
		end

		errors = errors + DUT.u_serializer.u_asserts.clock_fails
			+ DUT.u_serializer.u_asserts.hold_fails + DUT.u_serializer.u_asserts.busy_fails;
		$display("words %0d, pictures checked %0d, errors %0d", word_count, checked, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
